// File: rtl/cv_pad_pkg.sv
// Controller port types
// Host joystick layout and keypad codes
package cv_pad_pkg;

        localparam int N_PADS   = 2;
        localparam int N_KEYS   = 20;
        localparam int N_KEYPAD = 14;

        typedef logic [31:0]       host_joy_t;
        typedef logic [N_KEYS-1:0] key_vec_t;

        // Bit positions in the host joystick word
        localparam int HJ_RIGHT = 0;
        localparam int HJ_LEFT = 1;
        localparam int HJ_DOWN = 2;
        localparam int HJ_UP = 3;
        localparam int HJ_FIRE1 = 4;
        localparam int HJ_FIRE2 = 5;
        localparam int HJ_ASTERISK = 6;
        localparam int HJ_NUMBER = 7;
        localparam int HJ_DIGIT0 = 8;
        localparam int HJ_PURPLE = 18;
        localparam int HJ_BLUE = 19;

        // Key vector positions, keypad keys occupy 0 to N_KEYPAD-1
        localparam int POS_DIGIT0 = 0;
        localparam int POS_ASTERISK = 10;
        localparam int POS_NUMBER = 11;
        localparam int POS_PURPLE = 12;
        localparam int POS_BLUE = 13;
        localparam int POS_UP = 14;
        localparam int POS_DOWN = 15;
        localparam int POS_LEFT = 16;
        localparam int POS_RIGHT = 17;
        localparam int POS_FIRE1 = 18;
        localparam int POS_FIRE2 = 19;

        typedef enum logic [3:0] {
                KEY_0 = 4'b0011, KEY_1 = 4'b1110, KEY_2 = 4'b1101, KEY_3 = 4'b0110,
                KEY_4 = 4'b0001, KEY_5 = 4'b1001, KEY_6 = 4'b0111, KEY_7 = 4'b1100,
                KEY_8 = 4'b1000, KEY_9 = 4'b1011, KEY_ASTERISK = 4'b1010,
                KEY_NUMBER = 4'b0101, KEY_PURPLE = 4'b0100, KEY_BLUE = 4'b0010,
                KEY_NONE = 4'b1111
        } key_code_e;

        // Port code for each keypad position, in key vector order
        localparam key_code_e KEY_CODES [N_KEYPAD] = '{
                KEY_0, KEY_1, KEY_2, KEY_3, KEY_4, KEY_5, KEY_6, KEY_7, KEY_8, KEY_9,
                KEY_ASTERISK, KEY_NUMBER, KEY_PURPLE, KEY_BLUE
        };

endpackage

// File: rtl/cv_sys_pkg.sv
// System configuration types
// Register map, RAM modes and cartridge loader constants
package cv_sys_pkg;

        // ============================================================
        // APB register map
        // ============================================================
        typedef logic [3:0] apb_addr_t;

        localparam apb_addr_t REG_CTRL   = 4'h0;
        localparam apb_addr_t REG_STATUS = 4'h4;

        // REG_CTRL fields
        localparam int CTRL_SWAP_BIT = 0;
        localparam int CTRL_RAM_LSB  = 1;
        localparam int CTRL_RAM_MSB  = 2;

        // RAM size modes, the unnamed value 3 acts as SGM
        typedef enum logic [1:0] {
                RAM_1K  = 2'd0,
                RAM_8K  = 2'd1,
                RAM_SGM = 2'd2
        } ram_size_e;

        localparam int RAM_1K_AW = 10;
        localparam int RAM_8K_AW = 13;

        // ============================================================
        // Cartridge loader
        // ============================================================
        typedef logic [5:0] cart_page_t;

        localparam int IOCTL_AW = 25;

        // Download index of an SG-1000 image
        localparam logic [4:0] SG_INDEX = 5'd2;
        // 8K block at 0x2000 that probes for expansion RAM
        localparam logic [11:0] EXT_BLOCK = 12'd1;

endpackage

// File: rtl/cv_pad_if.sv
// Controller pad interface
`timescale 1ns/10ps

interface cv_pad_if import cv_pad_pkg::*; ();

        // Active-high keys in key vector order
        key_vec_t    keys;

        // Active-low selects from the console
        logic        sel_keypad_n;
        logic        sel_joy_n;

        // Encoded port value
        logic [3:0]  port_nib;
        logic        fire_n;

        modport router (
                output keys
        );

        modport encoder (
                input  keys, sel_keypad_n, sel_joy_n,
                output port_nib, fire_n
        );

endinterface

// File: rtl/cv_cfg_regs.sv
// Configuration registers
// APB slave for swap and RAM size settings
`timescale 1ns/10ps

module cv_cfg_regs import cv_sys_pkg::*; (
        input  logic        clk_sys,
        input  logic        reset_i,

        // APB slave, no wait states
        input  logic        psel_i,
        input  logic        penable_i,
        input  logic        pwrite_i,
        input  apb_addr_t   paddr_i,
        input  logic [7:0]  pwdata_i,
        output logic [7:0]  prdata_o,

        // Loader status for readback
        input  logic        sg1000_i,
        input  logic        extram_i,
        input  cart_page_t  cart_pages_i,

        output logic        swap_o,
        output ram_size_e   ram_size_o
);

        logic access;
        logic ctrl_wr;

        // Access phase of a transfer
        assign access  = psel_i & penable_i;
        assign ctrl_wr = access & pwrite_i & (paddr_i == REG_CTRL);

        // ============================================================
        // Control register
        // ============================================================
        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        swap_o     <= 1'b0;
                        ram_size_o <= RAM_1K;
                end else if (ctrl_wr) begin
                        swap_o     <= pwdata_i[CTRL_SWAP_BIT];
                        ram_size_o <= ram_size_e'(pwdata_i[CTRL_RAM_MSB:CTRL_RAM_LSB]);
                end
        end

        // ============================================================
        // Read mux
        // ============================================================
        always_comb begin
                prdata_o = '0;
                if (access && !pwrite_i) begin
                        case (paddr_i)
                                REG_CTRL: begin
                                        prdata_o[CTRL_SWAP_BIT] = swap_o;
                                        prdata_o[CTRL_RAM_MSB:CTRL_RAM_LSB] = ram_size_o;
                                end
                                REG_STATUS: begin
                                        prdata_o = {cart_pages_i, extram_i, sg1000_i};
                                end
                                // Unmapped addresses read zero
                                default: begin
                                        prdata_o = '0;
                                end
                        endcase
                end
        end

endmodule

// File: rtl/cv_joy_router.sv
// Joystick router
// Player swap and host bit reordering
`timescale 1ns/10ps

module cv_joy_router import cv_pad_pkg::*; (
        input  host_joy_t        joy_a_i,
        input  host_joy_t        joy_b_i,
        input  logic             swap_i,
        cv_pad_if.router         pads [N_PADS]
);

        // Host word to key vector order
        function automatic key_vec_t map_keys(input host_joy_t joy);
                key_vec_t k;
                for (int d = 0; d < 10; d++) begin
                        k[POS_DIGIT0 + d] = joy[HJ_DIGIT0 + d];
                end
                k[POS_ASTERISK] = joy[HJ_ASTERISK];
                k[POS_NUMBER]   = joy[HJ_NUMBER];
                k[POS_PURPLE]   = joy[HJ_PURPLE];
                k[POS_BLUE]     = joy[HJ_BLUE];
                k[POS_UP]       = joy[HJ_UP];
                k[POS_DOWN]     = joy[HJ_DOWN];
                k[POS_LEFT]     = joy[HJ_LEFT];
                k[POS_RIGHT]    = joy[HJ_RIGHT];
                k[POS_FIRE1]    = joy[HJ_FIRE1];
                k[POS_FIRE2]    = joy[HJ_FIRE2];
                return k;
        endfunction

        host_joy_t joy_p0;
        host_joy_t joy_p1;

        // Player 0 takes joy_a unless swapped
        assign joy_p0 = swap_i ? joy_b_i : joy_a_i;
        assign joy_p1 = swap_i ? joy_a_i : joy_b_i;

        assign pads[0].keys = map_keys(joy_p0);
        assign pads[1].keys = map_keys(joy_p1);

endmodule

// File: rtl/cv_pad_encoder.sv
// Controller port encoder
`timescale 1ns/10ps

module cv_pad_encoder import cv_pad_pkg::*; (
        cv_pad_if.encoder pad
);

        key_code_e   kp_nib;
        logic        kp_fire_n;
        logic [3:0]  joy_nib;
        logic        joy_fire_n;

        // ============================================================
        // Keypad side
        // ============================================================
        // Scan from the top so the lowest pressed position wins
        always_comb begin
                kp_nib    = KEY_NONE;
                kp_fire_n = 1'b1;
                if (!pad.sel_keypad_n) begin
                        for (int i = N_KEYPAD - 1; i >= 0; i--) begin
                                if (pad.keys[i]) begin
                                        kp_nib = KEY_CODES[i];
                                end
                        end
                        // Fire 2 sits on the keypad strobe
                        kp_fire_n = ~pad.keys[POS_FIRE2];
                end
        end

        // ============================================================
        // Joystick side
        // ============================================================
        always_comb begin
                joy_nib    = 4'b1111;
                joy_fire_n = 1'b1;
                if (!pad.sel_joy_n) begin
                        joy_nib = ~{pad.keys[POS_UP], pad.keys[POS_DOWN],
                                    pad.keys[POS_LEFT], pad.keys[POS_RIGHT]};
                        joy_fire_n = ~pad.keys[POS_FIRE1];
                end
        end

        // Both sides share the open-collector port lines
        assign pad.port_nib = kp_nib & joy_nib;
        assign pad.fire_n   = kp_fire_n & joy_fire_n;

endmodule

// File: rtl/cv_cart_map.sv
// Cartridge loader and RAM address map
`timescale 1ns/10ps

module cv_cart_map import cv_sys_pkg::*; #(
        // CPU RAM address width, 13 or more
        parameter int RAM_AW = 15
) (
        input  logic                clk_sys,
        input  logic                reset_i,

        input  logic                ioctl_wr_i,
        input  logic [IOCTL_AW-1:0] ioctl_addr_i,
        input  logic [7:0]          ioctl_index_i,
        input  logic [7:0]          ioctl_dout_i,

        input  ram_size_e           ram_size_i,
        input  logic [RAM_AW-1:0]   cpu_ram_a_i,
        output logic [RAM_AW-1:0]   ram_a_o,

        output logic                sg1000_o,
        output logic                extram_o,
        output cart_page_t          cart_pages_o
);

        localparam logic [RAM_AW-1:0] MASK_1K = RAM_AW'({RAM_1K_AW{1'b1}});
        localparam logic [RAM_AW-1:0] MASK_8K = RAM_AW'({RAM_8K_AW{1'b1}});

        logic [RAM_AW-1:0] ram_mask;

        // ============================================================
        // Download tracking
        // ============================================================
        always_ff @(posedge clk_sys) begin
                if (reset_i) begin
                        sg1000_o     <= 1'b0;
                        extram_o     <= 1'b0;
                        cart_pages_o <= '0;
                end else if (ioctl_wr_i) begin
                        cart_pages_o <= ioctl_addr_i[19:14];
                        // New image starts
                        if (ioctl_addr_i == '0) begin
                                extram_o <= 1'b0;
                                sg1000_o <= (ioctl_index_i[4:0] == SG_INDEX);
                        end
                        // SG-1000 image filled with FF at 0x2000 means extra RAM
                        if (ioctl_addr_i[24:13] == EXT_BLOCK && sg1000_o) begin
                                extram_o <= ((ioctl_addr_i[12:0] == '0) | extram_o) &
                                            (&ioctl_dout_i);
                        end
                end
        end

        // ============================================================
        // RAM address mask
        // ============================================================
        always_comb begin
                case (ram_size_i)
                        RAM_8K:  ram_mask = MASK_8K;
                        RAM_1K:  ram_mask = MASK_1K;
                        // SGM on SG-1000 is only 8K
                        default: ram_mask = sg1000_o ? MASK_8K : '1;
                endcase
                if (extram_o) begin
                        ram_mask = '1;
                end
        end

        assign ram_a_o = cpu_ram_a_i & ram_mask;

endmodule

// File: rtl/cv_ctrl_top.sv
// Console glue top level
`timescale 1ns/10ps

module cv_ctrl_top import cv_pad_pkg::*, cv_sys_pkg::*; #(
        parameter int RAM_AW = 15
) (
        input  logic                     clk_sys,
        input  logic                     reset_i,

        input  logic                     psel_i,
        input  logic                     penable_i,
        input  logic                     pwrite_i,
        input  apb_addr_t                paddr_i,
        input  logic [7:0]               pwdata_i,
        output logic [7:0]               prdata_o,

        input  logic                     ioctl_wr_i,
        input  logic [IOCTL_AW-1:0]      ioctl_addr_i,
        input  logic [7:0]               ioctl_index_i,
        input  logic [7:0]               ioctl_dout_i,

        input  host_joy_t                joy_a_i,
        input  host_joy_t                joy_b_i,
        input  logic [N_PADS-1:0]        ctrl_sel_keypad_n_i,
        input  logic [N_PADS-1:0]        ctrl_sel_joy_n_i,
        output logic [N_PADS-1:0][3:0]   ctrl_nib_o,
        output logic [N_PADS-1:0]        ctrl_fire_n_o,

        input  logic [RAM_AW-1:0]        cpu_ram_a_i,
        output logic [RAM_AW-1:0]        ram_a_o
);

        logic        swap;
        ram_size_e   ram_size;
        logic        sg1000;
        logic        extram;
        cart_page_t  cart_pages;

        cv_pad_if pad_if [N_PADS] ();

        cv_cfg_regs cv_cfg_regs_inst (
                .clk_sys, .reset_i, .psel_i, .penable_i, .pwrite_i, .paddr_i,
                .pwdata_i, .prdata_o, .sg1000_i(sg1000), .extram_i(extram),
                .cart_pages_i(cart_pages), .swap_o(swap), .ram_size_o(ram_size)
        );

        cv_cart_map #(.RAM_AW(RAM_AW)) cv_cart_map_inst (
                .clk_sys, .reset_i, .ioctl_wr_i, .ioctl_addr_i, .ioctl_index_i,
                .ioctl_dout_i, .ram_size_i(ram_size), .cpu_ram_a_i, .ram_a_o,
                .sg1000_o(sg1000), .extram_o(extram), .cart_pages_o(cart_pages)
        );

        cv_joy_router cv_joy_router_inst (
                .joy_a_i, .joy_b_i, .swap_i(swap), .pads(pad_if)
        );

        // One encoder per player
        for (genvar g = 0; g < N_PADS; g++) begin : gen_pad
                assign pad_if[g].sel_keypad_n = ctrl_sel_keypad_n_i[g];
                assign pad_if[g].sel_joy_n    = ctrl_sel_joy_n_i[g];

                cv_pad_encoder cv_pad_encoder_inst (
                        .pad(pad_if[g])
                );

                assign ctrl_nib_o[g]    = pad_if[g].port_nib;
                assign ctrl_fire_n_o[g] = pad_if[g].fire_n;
        end

endmodule

// File: include/tb_cv_ctrl_checks.svh
// Testbench compare tasks, bus tasks and reference models
`ifndef TB_CV_CTRL_CHECKS_SVH
`define TB_CV_CTRL_CHECKS_SVH

function automatic string mismatch_line(input string name, input logic [31:0] exp,
                                        input logic [31:0] act);
        return $sformatf("FAILED at %0t: %s expected %0h got %0h", $time, name, exp, act);
endfunction

task automatic check_nib(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp)
                stop_with_error(mismatch_line(name, exp, act));
endtask

task automatic check_fire(input string name, input logic exp, input logic act);
        if (act !== exp)
                stop_with_error(mismatch_line(name, exp, act));
endtask

task automatic check_ram_a(input string name, input logic [RAM_AW-1:0] exp,
                           input logic [RAM_AW-1:0] act);
        if (act !== exp)
                stop_with_error(mismatch_line(name, exp, act));
endtask

task automatic check_reg(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
                stop_with_error(mismatch_line(name, exp, act));
endtask

// ============================================================
// APB master without wait states
// ============================================================
task automatic apb_write(input apb_addr_t addr, input logic [7:0] data);
        next_drive();
        psel_i   = 1'b1;
        pwrite_i = 1'b1;
        paddr_i  = addr;
        pwdata_i = data;
        next_drive();
        penable_i = 1'b1;
        // Write lands on the edge before this drive point
        next_drive();
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
endtask

task automatic apb_read(input apb_addr_t addr, output logic [7:0] data);
        next_drive();
        psel_i  = 1'b1;
        paddr_i = addr;
        next_drive();
        penable_i = 1'b1;
        @(negedge clk_sys);
        data = prdata_o;
        next_drive();
        psel_i    = 1'b0;
        penable_i = 1'b0;
endtask

// ============================================================
// Reference models
// ============================================================
// Keypad code straight from the host word
// Digit 0 has top priority
function automatic logic [3:0] keypad_model(input host_joy_t joy);
        int         bits [14] = '{8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 6, 7, 18, 19};
        logic [3:0] codes [14] = '{4'b0011, 4'b1110, 4'b1101, 4'b0110, 4'b0001, 4'b1001,
                                   4'b0111, 4'b1100, 4'b1000, 4'b1011, 4'b1010, 4'b0101,
                                   4'b0100, 4'b0010};
        logic [3:0] code;
        code = 4'b1111;
        for (int i = 0; i < 14; i++) begin
                if (joy[bits[i]] && code == 4'b1111)
                        code = codes[i];
        end
        return code;
endfunction

// Returns the port nibble above the fire line
function automatic logic [4:0] encode_model(input host_joy_t joy, input logic kp_n,
                                            input logic js_n);
        logic [3:0] kp;
        logic [3:0] js;
        kp = kp_n ? 4'b1111 : keypad_model(joy);
        // Host bits 3 to 0 are up, down, left and right
        js = js_n ? 4'b1111 : ~joy[3:0];
        return {kp & js, (kp_n | ~joy[5]) & (js_n | ~joy[4])};
endfunction

function automatic logic [RAM_AW-1:0] mask_model(input logic [1:0] size, input logic sg,
                                                 input logic ext, input logic [RAM_AW-1:0] a);
        if (ext || (size >= 2'd2 && !sg))
                return a;
        if (size == 2'd0)
                return a & RAM_AW'('h3FF);
        return a & RAM_AW'('h1FFF);
endfunction

`endif

// File: verification/tb_cv_ctrl.sv
// Console glue testbench
`timescale 1ns/10ps

module tb_cv_ctrl import cv_pad_pkg::*, cv_sys_pkg::*; ();

        localparam int RAM_AW     = 15;
        localparam int RESET_WAIT = 50;

        typedef struct packed {
                host_joy_t  joy;
                logic       kp_n;
                logic       js_n;
                logic [3:0] nib;
                logic       fire_n;
        } pad_row_t;

        // Single keys and select combinations on player 0
        localparam pad_row_t PAD_ROWS [12] = '{
                '{32'h0000_0100, 1'b0, 1'b1, KEY_0, 1'b1},
                '{32'h0002_0000, 1'b0, 1'b1, KEY_9, 1'b1},
                '{32'h0000_0040, 1'b0, 1'b1, KEY_ASTERISK, 1'b1},
                '{32'h0000_0080, 1'b0, 1'b1, KEY_NUMBER, 1'b1},
                '{32'h0008_0000, 1'b0, 1'b1, KEY_BLUE, 1'b1},
                '{32'h0000_8800, 1'b0, 1'b1, KEY_3, 1'b1},
                '{32'h0000_0000, 1'b0, 1'b1, KEY_NONE, 1'b1},
                '{32'h0000_0020, 1'b0, 1'b1, KEY_NONE, 1'b0},
                '{32'h0000_0008, 1'b1, 1'b0, 4'b0111, 1'b1},
                '{32'h0000_0011, 1'b1, 1'b0, 4'b1110, 1'b0},
                '{32'h0000_2002, 1'b0, 1'b0, 4'b1001, 1'b1},
                '{32'hFFFF_FFFF, 1'b1, 1'b1, 4'b1111, 1'b1}
        };

        // Columns are RAM size, sg1000 and extram
        localparam logic [3:0] MASK_ROWS [10] = '{
                4'b00_0_0, 4'b01_0_0, 4'b10_0_0, 4'b11_0_0, 4'b00_1_0,
                4'b01_1_0, 4'b10_1_0, 4'b11_1_0, 4'b10_1_1, 4'b00_1_1
        };

        logic                   clk_sys;
        logic                   reset_i;
        logic                   psel_i, penable_i, pwrite_i;
        apb_addr_t              paddr_i;
        logic [7:0]             pwdata_i, prdata_o, rd;
        logic                   ioctl_wr_i;
        logic [IOCTL_AW-1:0]    ioctl_addr_i;
        logic [7:0]             ioctl_index_i, ioctl_dout_i;
        host_joy_t              joy_a_i, joy_b_i;
        logic [N_PADS-1:0]      ctrl_sel_keypad_n_i, ctrl_sel_joy_n_i, ctrl_fire_n_o;
        logic [N_PADS-1:0][3:0] ctrl_nib_o;
        logic [RAM_AW-1:0]      cpu_ram_a_i, ram_a_o;
        logic                   exp_swap;
        logic [31:0]            rnd;
        logic [31:0]            lcg_state = 32'ha3a88954;

        cv_ctrl_top #(.RAM_AW(RAM_AW)) cv_ctrl_top_inst (
                .clk_sys, .reset_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
                .prdata_o, .ioctl_wr_i, .ioctl_addr_i, .ioctl_index_i, .ioctl_dout_i,
                .joy_a_i, .joy_b_i, .ctrl_sel_keypad_n_i, .ctrl_sel_joy_n_i, .ctrl_nib_o,
                .ctrl_fire_n_o, .cpu_ram_a_i, .ram_a_o
        );

        `include "tb_cv_ctrl_checks.svh"

        task automatic stop_with_error(input string msg);
                $display("%s", msg);
                $display("Checks failed");
                $fatal(1);
        endtask

        task automatic next_drive();
                @(posedge clk_sys);
                #5;
        endtask

        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        task automatic wait_reset_release();
                int cycles;
                cycles = 0;
                while (reset_i !== 1'b0 && cycles < RESET_WAIT) begin
                        @(posedge clk_sys);
                        cycles++;
                end
                if (reset_i !== 1'b0)
                        stop_with_error("Reset was still asserted after the wait limit");
        endtask

        // Router model picks the host word for the encoder model
        task automatic check_pads();
                host_joy_t  joy;
                logic [4:0] exp;
                for (int p = 0; p < N_PADS; p++) begin
                        joy = ((p == 0) != exp_swap) ? joy_a_i : joy_b_i;
                        exp = encode_model(joy, ctrl_sel_keypad_n_i[p], ctrl_sel_joy_n_i[p]);
                        check_nib($sformatf("ctrl_nib_o[%0d]", p), exp[4:1], ctrl_nib_o[p]);
                        check_fire($sformatf("ctrl_fire_n_o[%0d]", p), exp[0], ctrl_fire_n_o[p]);
                end
        endtask

        task automatic ioctl_write(input logic [IOCTL_AW-1:0] addr, input logic [7:0] index,
                                   input logic [7:0] data);
                next_drive();
                ioctl_wr_i    = 1'b1;
                ioctl_addr_i  = addr;
                ioctl_index_i = index;
                ioctl_dout_i  = data;
                next_drive();
                ioctl_wr_i = 1'b0;
        endtask

        // Index 2 marks an SG-1000 image
        // FF at 0x2000 then flags extra RAM
        task automatic set_flags(input logic sg, input logic ext);
                ioctl_write('0, sg ? 8'd2 : 8'd1, 8'h00);
                if (ext)
                        ioctl_write(IOCTL_AW'('h2000), 8'd2, 8'hFF);
        endtask

        initial begin
                clk_sys = 1'b0;
                forever #50 clk_sys = ~clk_sys;
        end

        initial begin
                reset_i = 1'b1;
                repeat (10) @(posedge clk_sys);
                #5;
                reset_i = 1'b0;
        end

        initial begin
                psel_i              = 1'b0;
                penable_i           = 1'b0;
                pwrite_i            = 1'b0;
                paddr_i             = '0;
                pwdata_i            = '0;
                ioctl_wr_i          = 1'b0;
                ioctl_addr_i        = '0;
                ioctl_index_i       = '0;
                ioctl_dout_i        = '0;
                joy_a_i             = '0;
                joy_b_i             = '0;
                ctrl_sel_keypad_n_i = '1;
                ctrl_sel_joy_n_i    = '1;
                cpu_ram_a_i         = '0;
                exp_swap            = 1'b0;
                wait_reset_release();

                // ============================================================
                // Reset state
                // ============================================================
                apb_read(REG_CTRL, rd);
                check_reg("REG_CTRL", 8'h00, rd);
                apb_read(REG_STATUS, rd);
                check_reg("REG_STATUS", 8'h00, rd);
                next_drive();
                cpu_ram_a_i = '1;
                @(negedge clk_sys);
                check_ram_a("ram_a_o", RAM_AW'('h3FF), ram_a_o);

                // ============================================================
                // Controller ports
                // ============================================================
                foreach (PAD_ROWS[i]) begin
                        next_drive();
                        joy_a_i             = PAD_ROWS[i].joy;
                        ctrl_sel_keypad_n_i = {1'b1, PAD_ROWS[i].kp_n};
                        ctrl_sel_joy_n_i    = {1'b1, PAD_ROWS[i].js_n};
                        @(negedge clk_sys);
                        check_nib("ctrl_nib_o[0]", PAD_ROWS[i].nib, ctrl_nib_o[0]);
                        check_fire("ctrl_fire_n_o[0]", PAD_ROWS[i].fire_n, ctrl_fire_n_o[0]);
                        check_pads();
                end
                // Sparse random words so that later keys also win
                repeat (200) begin
                        next_drive();
                        joy_a_i = lcg_next() & lcg_next();
                        joy_b_i = lcg_next() & lcg_next();
                        rnd     = lcg_next();
                        ctrl_sel_keypad_n_i = rnd[17:16];
                        ctrl_sel_joy_n_i    = rnd[19:18];
                        @(negedge clk_sys);
                        check_pads();
                end

                // Swap applies in the cycle after the write edge
                apb_write(REG_CTRL, 8'h01);
                exp_swap            = 1'b1;
                joy_a_i             = 32'h0000_0100;
                joy_b_i             = 32'h0000_0200;
                ctrl_sel_keypad_n_i = 2'b00;
                ctrl_sel_joy_n_i    = 2'b11;
                @(negedge clk_sys);
                check_nib("ctrl_nib_o[0]", KEY_1, ctrl_nib_o[0]);
                check_pads();
                apb_read(REG_CTRL, rd);
                check_reg("REG_CTRL", 8'h01, rd);
                // Read data stays zero between accesses
                @(negedge clk_sys);
                check_reg("prdata_o", 8'h00, prdata_o);
                // Unmapped address reads zero
                apb_read(4'h8, rd);
                check_reg("prdata_o", 8'h00, rd);

                // ============================================================
                // Cartridge download
                // ============================================================
                set_flags(1'b1, 1'b0);
                for (int a = 'h2000; a < 'h2010; a++) begin
                        ioctl_write(IOCTL_AW'(a), 8'd2, 8'hFF);
                end
                // Pages 7 from the last address
                ioctl_write(IOCTL_AW'('h1C000), 8'd2, 8'h5A);
                apb_read(REG_STATUS, rd);
                check_reg("REG_STATUS", 8'h1F, rd);
                set_flags(1'b0, 1'b0);
                apb_read(REG_STATUS, rd);
                check_reg("REG_STATUS", 8'h00, rd);

                // RAM size modes against loader flags
                foreach (MASK_ROWS[i]) begin
                        set_flags(MASK_ROWS[i][1], MASK_ROWS[i][0]);
                        apb_write(REG_CTRL, {5'b0, MASK_ROWS[i][3:2], 1'b0});
                        exp_swap = 1'b0;
                        apb_read(REG_CTRL, rd);
                        check_reg("REG_CTRL", {5'b0, MASK_ROWS[i][3:2], 1'b0}, rd);
                        // First address is all ones so every mask bit is seen
                        for (int k = 0; k < 4; k++) begin
                                next_drive();
                                cpu_ram_a_i = (k == 0) ? '1 : RAM_AW'(lcg_next() >> 16);
                                @(negedge clk_sys);
                                check_ram_a("ram_a_o", mask_model(MASK_ROWS[i][3:2],
                                            MASK_ROWS[i][1], MASK_ROWS[i][0], cpu_ram_a_i),
                                            ram_a_o);
                        end
                end

                $display("All checks passed");
                $finish;
        end

endmodule

// File: tb.f
+incdir+include
rtl/cv_pad_pkg.sv
rtl/cv_sys_pkg.sv
rtl/cv_pad_if.sv
rtl/cv_cfg_regs.sv
rtl/cv_joy_router.sv
rtl/cv_pad_encoder.sv
rtl/cv_cart_map.sv
rtl/cv_ctrl_top.sv
verification/tb_cv_ctrl.sv
